// ==== project.f ====
+incdir+src
src/issuePkg.sv
src/ringBufferControl.sv
src/hazardCheck.sv
src/commitTracker.sv
src/issueStage.sv
tb/issueClock.sv
tb/issueStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the issue stage testbench with Verilator.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module issueStageTb -f project.f -o issueSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/issueSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
	echo "Result: pass"
	exit 0
fi
echo "Result: fail"
exit 1

// ==== tb/issueStageTb.sv ====
// Random testbench for the issue stage with a cycle-level reference model.
// Stimulus is fixed by the seed; the burst phase needs at least 16 register indexes.
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issueStageTb;

	localparam int periodNs    = 4;
	localparam int stimCycles  = 2000;
	localparam int idleCycles  = 5;
	localparam int burstCycles = 80;
	localparam int drainCycles = `EXEC_LATENCY + 15;
	localparam int watchdogNs  = (stimCycles + `EXEC_LATENCY + 100) * periodNs;
	localparam int indexCount  = 1 << (`REG_NO_WIDTH + 1);

	// In-flight instruction with the edge at which it was accepted
	typedef struct packed {
		issuePkg::issue_t rec;
		logic [31:0]      acceptEdge;
	} flight_t;

	logic               clock;
	logic               reset;
	logic               req;
	logic               slice;
	issuePkg::instr_t   instr;
	logic               stall;
	logic               issueValid;
	issuePkg::issue_t   issued;
	issuePkg::hazard_t  hazards;
	logic               commitValid;
	issuePkg::entryNo_t commitNo;
	flight_t            inFlight [$];
	int                 errors;
	int                 checks;

	issueClock #(.periodNs(periodNs), .resetCycles(10)) i_issueClock (
		.clock (clock),
		.reset (reset)
	);

	issueStage i_issueStage (
		.clock       (clock),
		.reset       (reset),
		.req         (req),
		.slice       (slice),
		.instr       (instr),
		.stall       (stall),
		.issueValid  (issueValid),
		.issued      (issued),
		.hazards     (hazards),
		.commitValid (commitValid),
		.commitNo    (commitNo)
	);

	function automatic logic sameReg(issuePkg::operand_t a, issuePkg::operand_t b);
		return a.valid && b.valid && (a.index == b.index);
	endfunction

	// Hazards of an offered instruction against one in-flight instruction
	function automatic issuePkg::hazard_t pairHazards(issuePkg::instr_t off,
			issuePkg::instr_t ent, logic sl);
		issuePkg::operand_t offSrc [3];
		issuePkg::operand_t entSrc [3];
		issuePkg::hazard_t  h;
		offSrc = '{off.src1, off.src2, off.src3};
		entSrc = '{ent.src1, ent.src2, ent.src3};
		h = '0;
		h.waw = sameReg(off.dst, ent.dst);
		for (int i = 0; i < 3; i++) begin
			h.raw = h.raw | sameReg(offSrc[i], ent.dst);
			h.war = h.war | sameReg(off.dst, entSrc[i]);
			for (int j = 0; j < 3; j++) begin
				h.rar = h.rar | (sl && ent.sliceLen != '0 && sameReg(offSrc[i], entSrc[j]));
			end
		end
		return h;
	endfunction

	function automatic issuePkg::operand_t randomOperand();
		issuePkg::operand_t op;
		op.valid = 1'($urandom_range(0, 1));
		op.index = issuePkg::regIndex_t'($urandom_range(0, 3));
		op.index[`REG_NO_WIDTH] = 1'($urandom_range(0, 1)); // Vector flag
		return op;
	endfunction

	function automatic issuePkg::instr_t randomInstr();
		issuePkg::instr_t ins;
		ins.dst      = randomOperand();
		ins.src1     = randomOperand();
		ins.src2     = randomOperand();
		ins.src3     = randomOperand();
		ins.sliceLen = issuePkg::sliceLen_t'($urandom_range(0, 3));
		return ins;
	endfunction

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		assert (expected === actual) else begin
			errors++;
			$display("MISMATCH %s expected %0h actual %0h at %0t", name, expected, actual, $time);
		end
	endtask

	initial begin
		issuePkg::hazard_t  hazNow;
		issuePkg::hazard_t  expHaz;
		issuePkg::issue_t   expRec;
		issuePkg::entryNo_t writePtr;
		flight_t            entry;
		logic               expIssue;
		logic               expCommit;
		logic               expStall;
		logic               blocked;
		int                 burstNo;
		int                 accepted;
		int                 fullStalls;

		errors = 0;
		checks = 0;
		void'($urandom(58));
		req = 1'b0;
		slice = 1'b0;
		instr = '0;
		expHaz = '0;
		expRec = '0;
		writePtr = '0;
		expIssue = 1'b0;
		burstNo = 0;
		accepted = 0;
		fullStalls = 0;
		@(negedge reset);
		for (int n = 0; n < stimCycles; n++) begin
			@(posedge clock);
			#0.5;
			checkValue("issueValid", 32'(expIssue), 32'(issueValid));
			if (expIssue) begin
				checkValue("issued.instr", 32'(expRec.instr), 32'(issued.instr));
				checkValue("issued.entryNo", 32'(expRec.entryNo), 32'(issued.entryNo));
			end
			checkValue("hazards", 32'(expHaz), 32'(hazards));

			//////////////////////////////////////////////////////////////////////
			// Model update for the edge just passed
			//////////////////////////////////////////////////////////////////////
			while (inFlight.size() > 0 && inFlight[0].acceptEdge + `EXEC_LATENCY + 1 <= n) begin
				entry = inFlight.pop_front();
			end
			if (expIssue) begin
				entry.rec = expRec;
				entry.acceptEdge = 32'(n);
				inFlight.push_back(entry);
			end
			expCommit = inFlight.size() > 0 && inFlight[0].acceptEdge + `EXEC_LATENCY == n;
			checkValue("commitValid", 32'(expCommit), 32'(commitValid));
			if (expCommit) begin
				checkValue("commitNo", 32'(inFlight[0].rec.entryNo), 32'(commitNo));
			end

			// New request unless the last one is still stalled
			if (!(req && !expIssue)) begin
				if (n < idleCycles || n >= stimCycles - drainCycles) begin
					req = 1'b0;
				end else if (n < idleCycles + burstCycles) begin
					req = 1'b1; // Independent burst, distinct destinations
					slice = 1'b0;
					instr = '0;
					instr.dst.valid = 1'b1;
					instr.dst.index = issuePkg::regIndex_t'(burstNo % indexCount);
					instr.sliceLen = issuePkg::sliceLen_t'($urandom_range(0, 15));
					burstNo++;
				end else begin
					req = ($urandom_range(0, 3) != 0);
					slice = 1'($urandom_range(0, 1));
					instr = randomInstr();
				end
			end

			#1;
			hazNow = '0;
			for (int i = 0; i < inFlight.size(); i++) begin
				hazNow = hazNow | pairHazards(instr, inFlight[i].rec.instr, slice);
			end
			blocked = hazNow.raw || hazNow.war || hazNow.waw;
			expStall = req && (blocked || inFlight.size() == `HAZARD_ENTRIES);
			checkValue("stall", 32'(expStall), 32'(stall));
			expIssue = req && !expStall;
			expHaz = req ? hazNow : '0;
			if (req && !blocked && inFlight.size() == `HAZARD_ENTRIES) begin
				fullStalls++;
			end
			if (expIssue) begin
				expRec.instr = instr;
				expRec.entryNo = writePtr;
				writePtr = (32'(writePtr) == `HAZARD_ENTRIES - 1) ? '0 : writePtr + 1'b1;
				accepted++;
			end
		end

		assert (fullStalls > 0) else begin
			errors++;
			$display("ERROR: the table never filled, so no stall on a full table was seen");
		end
		$display("Summary: %0d checks, %0d errors, %0d issued, %0d full stalls",
			checks, errors, accepted, fullStalls);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdogNs);
		$display("ERROR: watchdog expired after %0d ns, the run did not complete", watchdogNs);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/issueClock.sv ====
// Free-running testbench clock. Reset is released a half nanosecond after
// the last reset edge, like all other stimulus.
`timescale 1ns/1ps
`default_nettype none

module issueClock #(
	parameter int periodNs    = 4,
	parameter int resetCycles = 10
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(periodNs / 2) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		#0.5;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== src/issueStage.sv ====
// Issue stage top. Commits come back from the fixed-latency model,
// no external execution units attach here.
`timescale 1ns/1ps
`default_nettype none

module issueStage (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               req,
	input  wire logic               slice,
	input  wire issuePkg::instr_t   instr,
	output logic                    stall,
	output logic                    issueValid,
	output issuePkg::issue_t        issued,
	output issuePkg::hazard_t       hazards,
	output logic                    commitValid,
	output issuePkg::entryNo_t      commitNo
);

	hazardCheck i_hazardCheck (
		.clock       (clock),
		.reset       (reset),
		.req         (req),
		.slice       (slice),
		.instr       (instr),
		.commitValid (commitValid),
		.commitNo    (commitNo),
		.stall       (stall),
		.issueValid  (issueValid),
		.issued      (issued),
		.hazards     (hazards)
	);

	// Entry numbers return in ring order
	commitTracker i_commitTracker (
		.clock       (clock),
		.reset       (reset),
		.issueValid  (issueValid),
		.issueNo     (issued.entryNo),
		.commitValid (commitValid),
		.commitNo    (commitNo)
	);

endmodule

`default_nettype wire

// ==== src/commitTracker.sv ====
// Fixed-latency stand-in for the execution units. Commits leave in issue
// order, EXEC_LATENCY cycles after each issue strobe.
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module commitTracker (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               issueValid,
	input  wire issuePkg::entryNo_t issueNo,
	output logic                    commitValid,
	output issuePkg::entryNo_t      commitNo
);

	localparam int countWidth = $clog2(`HAZARD_ENTRIES + 1) + 1;
	localparam issuePkg::entryNo_t lastNo = issuePkg::entryNo_t'(`HAZARD_ENTRIES - 1);

	logic [`EXEC_LATENCY-1:0] validPipe;
	issuePkg::entryNo_t       noPipe [`EXEC_LATENCY];
	logic [countWidth-1:0]    outstanding;
	issuePkg::entryNo_t       oldestNo;

	always_ff @(posedge clock) begin
		if (reset) begin
			validPipe <= '0;
		end else begin
			validPipe[0] <= issueValid;
			for (int i = 1; i < `EXEC_LATENCY; i++) begin
				validPipe[i] <= validPipe[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		noPipe[0] <= issueNo;
		for (int i = 1; i < `EXEC_LATENCY; i++) begin
			noPipe[i] <= noPipe[i-1];
		end
	end

	assign commitValid = validPipe[`EXEC_LATENCY-1];
	assign commitNo    = noPipe[`EXEC_LATENCY-1];

	//////////////////////////////////////////////////////////////////////
	// In-order check
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding <= '0;
			oldestNo    <= '0;
		end else begin
			outstanding <= outstanding + countWidth'(issueValid) - countWidth'(commitValid);
			if (commitValid) begin
				oldestNo <= (oldestNo == lastNo) ? '0 : oldestNo + 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		commitValid |-> (outstanding != '0) && (commitNo == oldestNo))
		else $error("commitTracker: commit out of order");

	assert property (@(posedge clock) disable iff (reset)
		outstanding <= countWidth'(`HAZARD_ENTRIES))
		else $error("commitTracker: more in flight than table entries");

endmodule

`default_nettype wire

// ==== src/hazardCheck.sv ====
// Hazard table and issue decision. stall is combinational from req and instr;
// instr must stay stable while stall is high.
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module hazardCheck (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               req,
	input  wire logic               slice,
	input  wire issuePkg::instr_t   instr,
	input  wire logic               commitValid,
	input  wire issuePkg::entryNo_t commitNo,
	output logic                    stall,
	output logic                    issueValid,
	output issuePkg::issue_t        issued,
	output issuePkg::hazard_t       hazards
);

	issuePkg::instr_t   hazardTable [`HAZARD_ENTRIES];
	issuePkg::hazard_t  hazNow;
	issuePkg::entryNo_t writeNo;
	issuePkg::entryNo_t readNo;
	logic               full;
	logic               tableEmpty;
	logic               blocked;
	logic               accept;

	function automatic logic opMatch(issuePkg::operand_t a, issuePkg::operand_t b);
		return a.valid & b.valid & (a.index == b.index); // Vector bit included
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Comparison against every live entry
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		issuePkg::operand_t offSrc [3];
		issuePkg::operand_t entSrc [3];
		logic               sliced;

		hazNow    = '0;
		offSrc[0] = instr.src1;
		offSrc[1] = instr.src2;
		offSrc[2] = instr.src3;
		for (int e = 0; e < `HAZARD_ENTRIES; e++) begin
			entSrc[0] = hazardTable[e].src1;
			entSrc[1] = hazardTable[e].src2;
			entSrc[2] = hazardTable[e].src3;
			sliced    = slice & (hazardTable[e].sliceLen != '0);
			hazNow.waw |= opMatch(instr.dst, hazardTable[e].dst);
			for (int s = 0; s < 3; s++) begin
				hazNow.raw |= opMatch(offSrc[s], hazardTable[e].dst);
				hazNow.war |= opMatch(instr.dst, entSrc[s]);
				for (int k = 0; k < 3; k++) begin
					hazNow.rar |= sliced & opMatch(offSrc[s], entSrc[k]);
				end
			end
		end
	end

	// RAR is reported only
	assign blocked = hazNow.raw | hazNow.war | hazNow.waw;
	assign stall   = req & (blocked | full);
	assign accept  = req & ~stall;

	//////////////////////////////////////////////////////////////////////
	// Table update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int e = 0; e < `HAZARD_ENTRIES; e++) begin
				hazardTable[e] <= '0;
			end
		end else begin
			if (commitValid) begin
				hazardTable[commitNo].dst.valid  <= 1'b0;
				hazardTable[commitNo].src1.valid <= 1'b0;
				hazardTable[commitNo].src2.valid <= 1'b0;
				hazardTable[commitNo].src3.valid <= 1'b0;
			end
			if (accept) begin
				hazardTable[writeNo] <= instr; // Never the committing slot
			end
		end
	end

	ringBufferControl i_ringBufferControl (
		.clock   (clock),
		.reset   (reset),
		.write   (accept),
		.read    (commitValid),
		.writeNo (writeNo),
		.readNo  (readNo),
		.full    (full),
		.empty   (tableEmpty)
	);

	//////////////////////////////////////////////////////////////////////
	// Registered outputs
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			issueValid <= 1'b0;
			hazards    <= '0;
		end else begin
			issueValid <= accept;
			hazards    <= req ? hazNow : '0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			issued.instr   <= instr;
			issued.entryNo <= writeNo;
		end
	end

	// Slot being filled was cleared by its earlier commit
	assert property (@(posedge clock) disable iff (reset)
		accept |-> !(hazardTable[writeNo].dst.valid | hazardTable[writeNo].src1.valid
			| hazardTable[writeNo].src2.valid | hazardTable[writeNo].src3.valid))
		else $error("hazardCheck: issue into a slot still in use");

	// Ring count and table valid bits agree; commit slot is the ring head
	assert property (@(posedge clock) disable iff (reset)
		(tableEmpty |-> (hazNow == '0)) and (commitValid |-> (commitNo == readNo)))
		else $error("hazardCheck: table out of step with ring");

endmodule

`default_nettype wire

// ==== src/ringBufferControl.sv ====
// Ring allocation of hazard table slots. Writes and reads are strobes;
// the caller must not write when full or read when empty.
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module ringBufferControl (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               write,
	input  wire logic               read,
	output issuePkg::entryNo_t      writeNo,
	output issuePkg::entryNo_t      readNo,
	output logic                    full,
	output logic                    empty
);

	localparam int countWidth = $clog2(`HAZARD_ENTRIES + 1);
	localparam issuePkg::entryNo_t lastNo = issuePkg::entryNo_t'(`HAZARD_ENTRIES - 1);

	logic [countWidth-1:0] count;

	assign full  = (count == countWidth'(`HAZARD_ENTRIES));
	assign empty = (count == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			writeNo <= '0;
			readNo  <= '0;
			count   <= '0;
		end else begin
			if (write) begin
				writeNo <= (writeNo == lastNo) ? '0 : writeNo + 1'b1;
			end
			if (read) begin
				readNo <= (readNo == lastNo) ? '0 : readNo + 1'b1;
			end
			case ({write, read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset) !(write && full))
		else $error("ringBufferControl: write while full");

	assert property (@(posedge clock) disable iff (reset) !(read && empty))
		else $error("ringBufferControl: read while empty");

endmodule

`default_nettype wire

// ==== src/issuePkg.sv ====
// Types shared by the issue stage. Widths follow issue_settings.svh.
`default_nettype none

`include "issue_settings.svh"

package issuePkg;

	// Vector flag in the top bit, register number below
	typedef logic [`REG_NO_WIDTH:0] regIndex_t;

	typedef logic [`SLICE_LEN_WIDTH-1:0] sliceLen_t;

	typedef logic [$clog2(`HAZARD_ENTRIES)-1:0] entryNo_t;

	typedef struct packed {
		logic      valid;
		regIndex_t index;
	} operand_t;

	typedef struct packed {
		operand_t  dst;
		operand_t  src1;
		operand_t  src2;
		operand_t  src3;
		sliceLen_t sliceLen;
	} instr_t;

	typedef struct packed {
		logic rar;
		logic raw;
		logic war;
		logic waw;
	} hazard_t;

	// Issued instruction with the table slot it holds
	typedef struct packed {
		instr_t   instr;
		entryNo_t entryNo;
	} issue_t;

endpackage

`default_nettype wire

// ==== src/issue_settings.svh ====
// Sizes of the issue stage. HAZARD_ENTRIES sets the table depth and the
// number of instructions that can be in flight at once.
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Hazard table depth
`define HAZARD_ENTRIES 8

// Register number bits, the vector flag sits above them
`define REG_NO_WIDTH 3

// Slice length field
`define SLICE_LEN_WIDTH 4

// Cycles from issue strobe to commit pulse
`define EXEC_LATENCY 10

`endif
